//--- run_sim.sh
#!/usr/bin/env bash
# Builds the stream cdc hub testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_stream_cdc_hub \
    -Mdir "$BUILD_DIR" \
    -f stream_cdc_hub.f

"./$BUILD_DIR/Vtb_stream_cdc_hub" | tee "$LOG"

if grep -qx "TEST PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- src/lane_clock_bridge.sv
//############################################################################
// lane clock bridge
// Carries one item at a time from clk1 to clk2 with a four-phase
// request/acknowledge handshake through two-flop synchronizers.
//############################################################################

`timescale 1ns/100ps

module lane_clock_bridge (
    input  logic                  clk1,
    input  logic                  reset1,
    input  logic                  clk2,
    input  logic                  reset2,
    input  stream_cdc_pkg::data_t sink_data,
    input  logic                  sink_error,
    input  logic                  sink_valid,
    output logic                  sink_ready,
    output stream_cdc_pkg::data_t source_data,
    output logic                  source_error,
    output logic                  source_valid,
    input  logic                  source_ready
);

    logic req;
    logic req_ff1;
    logic req_ff2;
    logic ack;
    logic ack_ff1;
    logic ack_ff2;

    // ready only once the previous handshake has fully returned to zero.
    assign sink_ready = ~req & ~ack_ff2;

    always_ff @(posedge clk1 or posedge reset1) begin
        if (reset1) begin
            req     <= 1'b0;
            ack_ff1 <= 1'b0;
            ack_ff2 <= 1'b0;
        end else begin
            req     <= (sink_valid & sink_ready) | (req & ~ack_ff2);
            ack_ff1 <= ack;
            ack_ff2 <= ack_ff1;
        end
    end

    // payload is written in clk1 and read in clk2; it only changes while req is low.
    always_ff @(posedge clk1) begin
        if (sink_valid && sink_ready) begin
            source_data  <= sink_data;
            source_error <= sink_error;
        end
    end

    always_ff @(posedge clk2 or posedge reset2) begin
        if (reset2) begin
            req_ff1      <= 1'b0;
            req_ff2      <= 1'b0;
            ack          <= 1'b0;
            source_valid <= 1'b0;
        end else begin
            req_ff1 <= req;
            req_ff2 <= req_ff1;
            // ack rises when the item is taken and falls after req has dropped.
            ack <= req_ff2 & (ack | (source_valid & source_ready));
            if (source_valid) begin
                source_valid <= ~source_ready;
            end else begin
                source_valid <= req_ff2 & ~ack;
            end
        end
    end

endmodule

//--- src/lane_dispatch.sv
//############################################################################
// lane dispatcher
// Holds one input item in the clk1 domain and routes it by channel number
// to its lane. Items with a channel beyond the lane count are dropped and
// flagged with a single-cycle pulse.
//############################################################################

`timescale 1ns/100ps

module lane_dispatch #(
    parameter int LANE_COUNT = 4
) (
    input  logic                                       clk1,
    input  logic                                       reset1,
    input  stream_cdc_pkg::data_t                      in_data,
    input  stream_cdc_pkg::lane_id_t                   in_channel,
    input  logic                                       in_error,
    input  logic                                       in_valid,
    output logic                                       in_ready,
    output logic                  [LANE_COUNT-1:0]     lane_valid,
    input  logic                  [LANE_COUNT-1:0]     lane_ready,
    output stream_cdc_pkg::data_t [LANE_COUNT-1:0]     lane_data,
    output logic                  [LANE_COUNT-1:0]     lane_error,
    output logic                                       bad_channel
);

    logic                     hold_valid;
    stream_cdc_pkg::data_t    hold_data;
    stream_cdc_pkg::lane_id_t hold_lane;
    logic                     hold_error;
    logic                     accept;
    logic                     chan_bad;
    logic                     drain;

    assign chan_bad = int'(in_channel) >= LANE_COUNT;
    assign drain    = |(lane_valid & lane_ready); // held item leaves this cycle.

    // the register counts as empty while it drains, so it refills on the same edge.
    assign in_ready = ~hold_valid | drain;
    assign accept   = in_valid & in_ready;

    always_comb begin
        for (int k = 0; k < LANE_COUNT; k++) begin
            lane_valid[k] = hold_valid && (int'(hold_lane) == k);
            lane_data[k]  = hold_data;
            lane_error[k] = hold_error;
        end
    end

    always_ff @(posedge clk1 or posedge reset1) begin
        if (reset1) begin
            hold_valid  <= 1'b0;
            bad_channel <= 1'b0;
        end else begin
            bad_channel <= accept & chan_bad; // one pulse per dropped item.
            if (accept && !chan_bad) begin
                hold_valid <= 1'b1;
            end else if (drain) begin
                hold_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk1) begin
        if (accept && !chan_bad) begin
            hold_data  <= in_data;
            hold_lane  <= in_channel;
            hold_error <= in_error;
        end
    end

endmodule

//--- src/lane_merge.sv
//############################################################################
// lane merger
// Collects crossed items in the clk2 domain in round-robin order and
// registers the granted item, tagged with its lane number, onto the output.
//############################################################################

`timescale 1ns/100ps

module lane_merge #(
    parameter int LANE_COUNT = 4
) (
    input  logic                                       clk2,
    input  logic                                       reset2,
    input  logic                  [LANE_COUNT-1:0]     cross_valid,
    output logic                  [LANE_COUNT-1:0]     cross_ready,
    input  stream_cdc_pkg::data_t [LANE_COUNT-1:0]     cross_data,
    input  logic                  [LANE_COUNT-1:0]     cross_error,
    output stream_cdc_pkg::data_t                      out_data,
    output stream_cdc_pkg::lane_id_t                   out_channel,
    output logic                                       out_error,
    output logic                                       out_valid,
    input  logic                                       out_ready
);

    stream_cdc_pkg::merge_state_t state;
    stream_cdc_pkg::lane_id_t     last_lane;
    stream_cdc_pkg::lane_id_t     grant;
    logic                         found;
    logic                         take;

    // search starts just after the lane served last.
    always_comb begin
        int idx;
        found = 1'b0;
        grant = '0;
        for (int i = 1; i <= LANE_COUNT; i++) begin
            idx = (int'(last_lane) + i) % LANE_COUNT;
            if (!found && cross_valid[idx]) begin
                found = 1'b1;
                grant = stream_cdc_pkg::lane_id_t'(idx);
            end
        end
    end

    assign take = (state == stream_cdc_pkg::scan) && found;

    always_comb begin
        for (int k = 0; k < LANE_COUNT; k++) begin
            cross_ready[k] = take && (int'(grant) == k); // single-cycle pulse.
        end
    end

    assign out_valid = (state == stream_cdc_pkg::present);

    always_ff @(posedge clk2 or posedge reset2) begin
        if (reset2) begin
            state     <= stream_cdc_pkg::scan;
            last_lane <= stream_cdc_pkg::lane_id_t'(LANE_COUNT - 1); // lane 0 goes first.
        end else begin
            case (state)
                stream_cdc_pkg::scan: begin
                    if (found) begin
                        state     <= stream_cdc_pkg::present;
                        last_lane <= grant;
                    end
                end
                stream_cdc_pkg::present: begin
                    if (out_ready) begin
                        state <= stream_cdc_pkg::scan;
                    end
                end
                default: begin
                    state <= stream_cdc_pkg::scan;
                end
            endcase
        end
    end

    // output payload only loads on a grant, so it holds while stalled.
    always_ff @(posedge clk2) begin
        if (take) begin
            out_data    <= cross_data[grant];
            out_error   <= cross_error[grant];
            out_channel <= grant;
        end
    end

endmodule

//--- src/stream_cdc_hub.sv
//############################################################################
// stream cdc hub
// Top level. Dispatches a clk1 stream over independent lane bridges and
// merges the lanes back into one clk2 stream.
//############################################################################

`timescale 1ns/100ps

module stream_cdc_hub #(
    parameter int LANE_COUNT = 4
) (
    input  logic                     clk1,
    input  logic                     reset1,
    input  logic                     clk2,
    input  logic                     reset2,
    input  stream_cdc_pkg::data_t    in_data,
    input  stream_cdc_pkg::lane_id_t in_channel,
    input  logic                     in_error,
    input  logic                     in_valid,
    output logic                     in_ready,
    output logic                     bad_channel,
    output stream_cdc_pkg::data_t    out_data,
    output stream_cdc_pkg::lane_id_t out_channel,
    output logic                     out_error,
    output logic                     out_valid,
    input  logic                     out_ready
);

    logic                  [LANE_COUNT-1:0] lane_valid;
    logic                  [LANE_COUNT-1:0] lane_ready;
    stream_cdc_pkg::data_t [LANE_COUNT-1:0] lane_data;
    logic                  [LANE_COUNT-1:0] lane_error;
    logic                  [LANE_COUNT-1:0] cross_valid;
    logic                  [LANE_COUNT-1:0] cross_ready;
    stream_cdc_pkg::data_t [LANE_COUNT-1:0] cross_data;
    logic                  [LANE_COUNT-1:0] cross_error;

    // the two-bit channel field cannot address more lanes than this.
    if (LANE_COUNT < 1 || LANE_COUNT > stream_cdc_pkg::MAX_LANES) begin : g_bad_count
        $error("LANE_COUNT out of range");
    end

    lane_dispatch #(
        .LANE_COUNT (LANE_COUNT)
    ) i_dispatch (
        .clk1        (clk1),
        .reset1      (reset1),
        .in_data     (in_data),
        .in_channel  (in_channel),
        .in_error    (in_error),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .lane_valid  (lane_valid),
        .lane_ready  (lane_ready),
        .lane_data   (lane_data),
        .lane_error  (lane_error),
        .bad_channel (bad_channel)
    );

    for (genvar k = 0; k < LANE_COUNT; k++) begin : g_lane
        lane_clock_bridge i_bridge (
            .clk1         (clk1),
            .reset1       (reset1),
            .clk2         (clk2),
            .reset2       (reset2),
            .sink_data    (lane_data[k]),
            .sink_error   (lane_error[k]),
            .sink_valid   (lane_valid[k]),
            .sink_ready   (lane_ready[k]),
            .source_data  (cross_data[k]),
            .source_error (cross_error[k]),
            .source_valid (cross_valid[k]),
            .source_ready (cross_ready[k])
        );
    end

    lane_merge #(
        .LANE_COUNT (LANE_COUNT)
    ) i_merge (
        .clk2        (clk2),
        .reset2      (reset2),
        .cross_valid (cross_valid),
        .cross_ready (cross_ready),
        .cross_data  (cross_data),
        .cross_error (cross_error),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_error   (out_error),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule

//--- src/stream_cdc_pkg.sv
//############################################################################
// stream cdc package
// Shared stream types, lane limits and the merger state encoding.
//############################################################################

package stream_cdc_pkg;

    // one byte of stream payload.
    typedef logic [7:0] data_t;

    // channel number of an item; two bits address up to four lanes.
    typedef logic [1:0] lane_id_t;

    // upper bound on the lane count of the hub.
    localparam int MAX_LANES = 4;

    // merger FSM states.
    typedef enum logic {
        scan,    // looking for a valid lane to grant
        present  // granted item sits on the output
    } merge_state_t;

endpackage

//--- stream_cdc_hub.f
src/stream_cdc_pkg.sv
src/lane_dispatch.sv
src/lane_clock_bridge.sv
src/lane_merge.sv
src/stream_cdc_hub.sv
verif/stream_cdc_hub_sva.sv
verif/tb_stream_cdc_hub.sv

//--- verif/stream_cdc_hub_sva.sv
//############################################################################
// stream cdc hub assertions
// Reset values, output hold under back-pressure and bad_channel pulses
// checked against the input handshake.
//############################################################################

`timescale 1ns/100ps

module stream_cdc_hub_sva #(
    parameter int LANE_COUNT = 4
) (
    input logic                     clk1,
    input logic                     reset1,
    input logic                     clk2,
    input logic                     reset2,
    input stream_cdc_pkg::lane_id_t in_channel,
    input logic                     in_valid,
    input logic                     in_ready,
    input logic                     bad_channel,
    input stream_cdc_pkg::data_t    out_data,
    input stream_cdc_pkg::lane_id_t out_channel,
    input logic                     out_error,
    input logic                     out_valid,
    input logic                     out_ready
);

    // a stalled output keeps its whole item until it is taken.
    a_out_hold: assert property (
        @(posedge clk2) disable iff (reset2)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
            && $stable(out_channel) && $stable(out_error)
    ) else $error("output stream changed while stalled");

    // every pulse follows a transfer whose channel has no lane.
    a_bad_pulse: assert property (
        @(posedge clk1) disable iff (reset1)
        bad_channel |-> $past(in_valid && in_ready && int'(in_channel) >= LANE_COUNT)
    ) else $error("bad_channel pulse without a dropped item");

    a_reset1_idle: assert property (
        @(posedge clk1) reset1 |-> in_ready && !bad_channel
    ) else $error("clk1 side not idle during reset");

    a_reset2_idle: assert property (
        @(posedge clk2) reset2 |-> !out_valid
    ) else $error("out_valid high during reset");

endmodule

bind stream_cdc_hub stream_cdc_hub_sva #(
    .LANE_COUNT (LANE_COUNT)
) i_sva (
    .clk1        (clk1),
    .reset1      (reset1),
    .clk2        (clk2),
    .reset2      (reset2),
    .in_channel  (in_channel),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .bad_channel (bad_channel),
    .out_data    (out_data),
    .out_channel (out_channel),
    .out_error   (out_error),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
);

//--- verif/tb_stream_cdc_hub.sv
//############################################################################
// stream cdc hub testbench
// Drives a mixed-channel stream through a three-lane hub, models the
// routing and checks each output item against per-lane queues.
//############################################################################

`timescale 1ns/100ps

module tb_stream_cdc_hub;

    localparam int TB_LANES   = 3;
    localparam int ITEM_WAIT  = 400;  // clk1 cycles an item may wait for in_ready.
    localparam int DRAIN_WAIT = 4000; // clk2 cycles for all lanes to empty.

    logic                     clk1;
    logic                     clk2;
    logic                     reset1;
    logic                     reset2;
    stream_cdc_pkg::data_t    in_data;
    stream_cdc_pkg::lane_id_t in_channel;
    logic                     in_error;
    logic                     in_valid;
    logic                     in_ready;
    logic                     bad_channel;
    stream_cdc_pkg::data_t    out_data;
    stream_cdc_pkg::lane_id_t out_channel;
    logic                     out_error;
    logic                     out_valid;
    logic                     out_ready;

    integer seed;
    int     error_count;
    int     check_count;
    int     out_count;
    int     bad_expected;
    int     bad_seen;
    bit     timed_out;
    bit     stall_mode;
    bit     run_done;

    // expected items of each lane as {error, data}.
    logic [8:0] exp_q [TB_LANES][$];

    stream_cdc_hub #(
        .LANE_COUNT (TB_LANES)
    ) i_dut (
        .clk1        (clk1),
        .reset1      (reset1),
        .clk2        (clk2),
        .reset2      (reset2),
        .in_data     (in_data),
        .in_channel  (in_channel),
        .in_error    (in_error),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .bad_channel (bad_channel),
        .out_data    (out_data),
        .out_channel (out_channel),
        .out_error   (out_error),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

    initial begin
        clk1 = 1'b0;
        forever #10 clk1 = ~clk1;
    end

    // clk2 is offset so that its edges never meet those of clk1.
    initial begin
        clk2 = 1'b0;
        #3.5;
        forever #7 clk2 = ~clk2;
    end

    initial begin : ready_drive
        logic [31:0] r;
        out_ready = 1'b0;
        forever begin
            @(negedge clk2);
            r = $random(seed);
            out_ready = stall_mode ? (r[1:0] != 2'b00) : 1'b1; // low about one cycle in four.
        end
    end

    // lane that carries an item, or -1 when its channel has no lane.
    function automatic int expected_lane(input stream_cdc_pkg::lane_id_t channel);
        if (int'(channel) < TB_LANES) begin
            return int'(channel);
        end
        return -1;
    endfunction

    // lane whose oldest expected item has this payload; the named lane wins a tie.
    function automatic int payload_lane(input stream_cdc_pkg::data_t data, input bit error,
                                        input int named);
        int         lane;
        logic [8:0] head;
        lane = -1;
        for (int k = TB_LANES - 1; k >= 0; k--) begin
            if (exp_q[k].size() != 0) begin
                head = exp_q[k][0];
                if (head === {error, data}) begin
                    lane = k;
                end
            end
        end
        if (exp_q[named].size() != 0) begin
            head = exp_q[named][0];
            if (head === {error, data}) begin
                lane = named;
            end
        end
        return lane;
    endfunction

    function automatic bit lanes_empty();
        bit                       empty;
        stream_cdc_pkg::lane_id_t idx;
        empty = 1'b1;
        for (int k = 0; k < TB_LANES; k++) begin
            idx = stream_cdc_pkg::lane_id_t'(k);
            if (exp_q[idx].size() != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    task automatic check_data(input stream_cdc_pkg::data_t got, input stream_cdc_pkg::data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: out_data got 0x%02h expected 0x%02h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_channel(input stream_cdc_pkg::lane_id_t got,
                                 input stream_cdc_pkg::lane_id_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: out_channel got 0x%0h expected 0x%0h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_error(input bit got, input bit exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: out_error got 0x%0h expected 0x%0h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        error_count++;
        $display("timeout: %s at %0t", what, $time);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk1);
    endtask

    // called at a falling clk1 edge; returns one falling edge after the transfer.
    task automatic send_item(input stream_cdc_pkg::data_t data,
                             input stream_cdc_pkg::lane_id_t channel, input logic error);
        int wait_cnt;
        wait_cnt = 0;
        if (timed_out) begin
            return;
        end
        in_data    = data;
        in_channel = channel;
        in_error   = error;
        in_valid   = 1'b1;
        while (in_ready !== 1'b1 && !timed_out) begin
            @(negedge clk1);
            wait_cnt++;
            if (wait_cnt > ITEM_WAIT) begin
                report_timeout("in_ready stayed low");
            end
        end
        if (!timed_out) begin
            if (expected_lane(channel) < 0) begin
                bad_expected++;
            end else begin
                exp_q[expected_lane(channel)].push_back({error, data});
            end
        end
        @(negedge clk1);
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int count);
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            send_item(r[7:0], r[9:8], r[10]);
            if (r[13:12] == 2'b00) begin
                idle(int'(r[15:14]) + 1);
            end
        end
    endtask

    task automatic wait_drain();
        int wait_cnt;
        wait_cnt = 0;
        while (!lanes_empty() && !timed_out) begin
            @(negedge clk2);
            wait_cnt++;
            if (wait_cnt > DRAIN_WAIT) begin
                report_timeout("expected items did not reach the output");
            end
        end
        idle(20); // late duplicates and bad_channel pulses show up here.
    endtask

    always @(posedge clk2) begin : compare_out
        logic [8:0] item;
        int         exp_lane;
        if (!reset2 && out_valid === 1'b1 && out_ready === 1'b1) begin
            out_count++;
            if (int'(out_channel) >= TB_LANES) begin
                error_count++;
                $display("output item on channel %0d, which has no lane, at %0t",
                         out_channel, $time);
            end else if (exp_q[out_channel].size() == 0) begin
                error_count++;
                $display("output item on lane %0d while none was expected at %0t",
                         out_channel, $time);
            end else begin
                exp_lane = payload_lane(out_data, out_error, int'(out_channel));
                item = exp_q[out_channel].pop_front();
                check_data(out_data, item[7:0]);
                check_error(out_error, item[8]);
                if (exp_lane >= 0) begin
                    check_channel(out_channel, stream_cdc_pkg::lane_id_t'(exp_lane));
                end
            end
        end
    end

    always @(posedge clk1) begin
        if (!reset1 && bad_channel === 1'b1) begin
            bad_seen++;
        end
    end

    initial begin : main_seq
        seed         = 32'h16c0bc76;
        error_count  = 0;
        check_count  = 0;
        out_count    = 0;
        bad_expected = 0;
        bad_seen     = 0;
        timed_out    = 1'b0;
        stall_mode   = 1'b0;
        run_done     = 1'b0;
        reset1       = 1'b1;
        reset2       = 1'b1;
        in_data      = '0;
        in_channel   = '0;
        in_error     = 1'b0;
        in_valid     = 1'b0;
        repeat (8) @(posedge clk1);
        @(negedge clk1);
        reset1 = 1'b0;
        reset2 = 1'b0;
        @(negedge clk1);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("bad_channel", bad_channel, 1'b0);

        send_item(8'ha5, 2'd0, 1'b0);
        send_item(8'h3c, 2'd1, 1'b1);
        send_item(8'h5a, 2'd2, 1'b0);
        wait_drain();

        // channel 3 has no lane in a three-lane hub.
        send_item(8'hc3, 2'd3, 1'b0);
        idle(3);
        send_item(8'h96, 2'd3, 1'b1);
        send_item(8'h0f, 2'd1, 1'b0);
        wait_drain();

        send_random(150);
        wait_drain();
        stall_mode = 1'b1;
        send_random(150);
        wait_drain();
        stall_mode = 1'b0;

        if (bad_seen != bad_expected) begin
            error_count++;
            $display("Error: bad_channel pulse count got 0x%0h expected 0x%0h",
                     bad_seen, bad_expected);
        end
        $display("checks %0d, errors %0d, outputs %0d, bad pulses %0d of %0d",
                 check_count, error_count, out_count, bad_seen, bad_expected);
        run_done = 1'b1;
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // a run stopped early by the simulator still ends with a verdict.
    final begin
        if (!run_done) begin
            $display("TEST FAILED");
        end
    end

endmodule
